/* logic/xpose_defs.svh */
/*
  Block-matrix transposer configuration
  Element width, tile shape and largest matrix size in tiles
*/

`ifndef XPOSE_DEFS_SVH
`define XPOSE_DEFS_SVH

// Bits per matrix element
`define XPOSE_DATA_WIDTH 8

// Elements per tile
`define XPOSE_TILE_ROWS 2
`define XPOSE_TILE_COLS 2

// Largest matrix in tiles, rows set FIFO depth, cols set FIFO count
`define XPOSE_MAX_ROWS 4
`define XPOSE_MAX_COLS 4

`endif

/* logic/xpose_pkg.sv */
/*
  Transposer types
  Element, flattened tile, position counters and shape values
*/

`include "xpose_defs.svh"

package xpose_pkg;

  localparam int ROW_CNT_W = (`XPOSE_MAX_ROWS > 1) ? $clog2(`XPOSE_MAX_ROWS) : 1;
  localparam int COL_CNT_W = (`XPOSE_MAX_COLS > 1) ? $clog2(`XPOSE_MAX_COLS) : 1;

  typedef logic [`XPOSE_DATA_WIDTH-1:0] elem_t;
  // Element (r,c) at index r*TILE_COLS+c
  typedef logic [`XPOSE_TILE_ROWS*`XPOSE_TILE_COLS*`XPOSE_DATA_WIDTH-1:0] tile_t;

  typedef logic [ROW_CNT_W-1:0] row_cnt_t;
  typedef logic [COL_CNT_W-1:0] col_cnt_t;

  // Shape values 0..max, one bit wider than the counters
  typedef logic [ROW_CNT_W:0] rows_cfg_t;
  typedef logic [COL_CNT_W:0] cols_cfg_t;

  typedef enum logic [1:0] {PH_IDLE, PH_LOAD, PH_DRAIN, PH_SETTLE} xp_phase_t;

endpackage

/* logic/tile_fifo.sv */
/*
  Tile FIFO
  First-word-fall-through buffer of whole tiles, one per tile row of a matrix
*/

`timescale 1ns/10ps

`include "xpose_defs.svh"

module tile_fifo
  import xpose_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  tile_t in_tile,
  input  logic  in_valid,
  output logic  in_ready,
  output tile_t out_tile,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int DEPTH = `XPOSE_MAX_ROWS;

  tile_t     mem [DEPTH];
  row_cnt_t  wr_ptr;
  row_cnt_t  rd_ptr;
  rows_cfg_t count;
  logic      wr_en;
  logic      rd_en;

  function automatic row_cnt_t ptr_next(input row_cnt_t p);
    return (p == row_cnt_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Head entry shows whenever not empty
  assign out_valid = (count != '0);
  assign out_tile  = mem[rd_ptr];
  // Full still takes a write when the head leaves in the same cycle
  assign in_ready  = (count != rows_cfg_t'(DEPTH)) || out_ready;
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_tile;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* logic/tile_transposer.sv */
/*
  Streaming tile transposer
  Buffers tiles in one FIFO per tile column, reads them back column by column
  and swaps the elements of each tile on the way out
*/

`timescale 1ns/10ps

`include "xpose_defs.svh"

module tile_transposer
  import xpose_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  rows_cfg_t act_rows,
  input  cols_cfg_t act_cols,
  input  tile_t     in_tile,
  input  logic      in_valid,
  output logic      in_ready,
  output tile_t     xp_tile,
  output logic      xp_valid,
  input  logic      xp_ready,
  output logic      busy
);

  localparam int TR   = `XPOSE_TILE_ROWS;
  localparam int TC   = `XPOSE_TILE_COLS;
  localparam int DW   = `XPOSE_DATA_WIDTH;
  localparam int NCOL = `XPOSE_MAX_COLS;

  xp_phase_t phase;
  row_cnt_t  in_row;
  col_cnt_t  in_col;
  col_cnt_t  out_row;
  row_cnt_t  out_col;
  row_cnt_t  last_row;
  col_cnt_t  last_col;
  logic      accepting;
  logic      in_fire;
  logic      in_last;
  logic      out_fire;
  logic      out_last;

  tile_t fifo_out_tile  [NCOL];
  logic  fifo_in_valid  [NCOL];
  logic  fifo_in_ready  [NCOL];
  logic  fifo_out_valid [NCOL];
  logic  fifo_out_ready [NCOL];
  tile_t head_tile;
  elem_t head_elem [TR*TC];

  assign last_row = row_cnt_t'(act_rows - 1'b1);
  assign last_col = col_cnt_t'(act_cols - 1'b1);

  // Input closed from the last input tile until the shape has reloaded
  assign accepting = (phase == PH_IDLE) || (phase == PH_LOAD);
  assign busy      = (phase == PH_LOAD) || (phase == PH_DRAIN);

  for (genvar i = 0; i < NCOL; i++) begin : g_col
    assign fifo_in_valid[i]  = in_valid && accepting && (in_col == col_cnt_t'(i));
    assign fifo_out_ready[i] = xp_ready && (out_row == col_cnt_t'(i));

    tile_fifo u_fifo (
      .clk       (clk),
      .rst       (rst),
      .in_tile   (in_tile),
      .in_valid  (fifo_in_valid[i]),
      .in_ready  (fifo_in_ready[i]),
      .out_tile  (fifo_out_tile[i]),
      .out_valid (fifo_out_valid[i]),
      .out_ready (fifo_out_ready[i])
    );
  end

  assign in_ready = accepting && fifo_in_ready[in_col];
  assign in_fire  = in_valid && in_ready;
  assign in_last  = (in_row == last_row) && (in_col == last_col);

  // Output row i of the result is input tile column i
  assign head_tile = fifo_out_tile[out_row];
  assign xp_valid  = fifo_out_valid[out_row];
  assign out_fire  = xp_valid && xp_ready;
  assign out_last  = (out_row == last_col) && (out_col == last_row);

  // Element (r,c) of the head tile lands at (c,r)
  for (genvar r = 0; r < TR; r++) begin : g_tr
    for (genvar c = 0; c < TC; c++) begin : g_tc
      assign head_elem[r*TC+c]          = head_tile[(r*TC+c)*DW +: DW];
      assign xp_tile[(c*TR+r)*DW +: DW] = head_elem[r*TC+c];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_row  <= '0;
      in_col  <= '0;
      out_row <= '0;
      out_col <= '0;
    end else begin
      // Input walks R x C in row-major order
      if (in_fire) begin
        if (in_col == last_col) begin
          in_col <= '0;
          in_row <= (in_row == last_row) ? '0 : in_row + 1'b1;
        end else begin
          in_col <= in_col + 1'b1;
        end
      end
      // Output walks C x R
      if (out_fire) begin
        if (out_col == last_row) begin
          out_col <= '0;
          out_row <= (out_row == last_col) ? '0 : out_row + 1'b1;
        end else begin
          out_col <= out_col + 1'b1;
        end
      end
    end
  end

  // Matrix phase, settle gives the shape latch one idle cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= PH_IDLE;
    end else begin
      case (phase)
        PH_IDLE, PH_LOAD: begin
          if (in_fire && in_last) begin
            phase <= PH_DRAIN;
          end else if (in_fire) begin
            phase <= PH_LOAD;
          end
        end
        PH_DRAIN: begin
          if (out_fire && out_last) begin
            phase <= PH_SETTLE;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

endmodule

/* logic/shape_latch.sv */
/*
  Shape latch
  Clamps the configured matrix size to 1..max tiles and holds it while busy
*/

`timescale 1ns/10ps

`include "xpose_defs.svh"

module shape_latch
  import xpose_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  rows_cfg_t cfg_rows,
  input  cols_cfg_t cfg_cols,
  input  logic      busy,
  output rows_cfg_t act_rows,
  output cols_cfg_t act_cols
);

  rows_cfg_t rows_clamped;
  cols_cfg_t cols_clamped;

  always_comb begin
    rows_clamped = cfg_rows;
    if (cfg_rows == '0) begin
      rows_clamped = rows_cfg_t'(1);
    end else if (cfg_rows > rows_cfg_t'(`XPOSE_MAX_ROWS)) begin
      rows_clamped = rows_cfg_t'(`XPOSE_MAX_ROWS);
    end

    cols_clamped = cfg_cols;
    if (cfg_cols == '0) begin
      cols_clamped = cols_cfg_t'(1);
    end else if (cfg_cols > cols_cfg_t'(`XPOSE_MAX_COLS)) begin
      cols_clamped = cols_cfg_t'(`XPOSE_MAX_COLS);
    end
  end

  // Frozen for the whole matrix
  always_ff @(posedge clk) begin
    if (rst) begin
      act_rows <= rows_cfg_t'(1);
      act_cols <= cols_cfg_t'(1);
    end else if (!busy) begin
      act_rows <= rows_clamped;
      act_cols <= cols_clamped;
    end
  end

endmodule

/* logic/out_slice.sv */
/*
  Output register slice
  Two-entry skid buffer, registered valid and ready at full throughput
*/

`timescale 1ns/10ps

module out_slice
  import xpose_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  tile_t xp_tile,
  input  logic  xp_valid,
  output logic  xp_ready,
  output tile_t out_tile,
  output logic  out_valid,
  input  logic  out_ready
);

  tile_t spare_tile;
  logic  spare_valid;
  logic  main_free;

  // Main register can take a new tile this cycle
  assign main_free = !out_valid || out_ready;
  assign xp_ready  = !spare_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid   <= 1'b0;
      spare_valid <= 1'b0;
    end else if (main_free) begin
      // Spare drains first to keep order
      out_valid   <= spare_valid || xp_valid;
      spare_valid <= 1'b0;
    end else if (xp_valid && xp_ready) begin
      spare_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      out_tile <= spare_valid ? spare_tile : xp_tile;
    end else if (xp_valid && xp_ready) begin
      spare_tile <= xp_tile;
    end
  end

endmodule

/* logic/xpose_top.sv */
/*
  Block-matrix transposer top
  Shape latch, tile transposer and output register slice
*/

`timescale 1ns/10ps

module xpose_top
  import xpose_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  rows_cfg_t cfg_rows,
  input  cols_cfg_t cfg_cols,
  input  tile_t     in_tile,
  input  logic      in_valid,
  output logic      in_ready,
  output tile_t     out_tile,
  output logic      out_valid,
  input  logic      out_ready
);

  rows_cfg_t act_rows;
  cols_cfg_t act_cols;
  logic      busy;
  tile_t     xp_tile;
  logic      xp_valid;
  logic      xp_ready;

  shape_latch u_shape (
    .clk      (clk),
    .rst      (rst),
    .cfg_rows (cfg_rows),
    .cfg_cols (cfg_cols),
    .busy     (busy),
    .act_rows (act_rows),
    .act_cols (act_cols)
  );

  tile_transposer u_xpose (
    .clk      (clk),
    .rst      (rst),
    .act_rows (act_rows),
    .act_cols (act_cols),
    .in_tile  (in_tile),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .xp_tile  (xp_tile),
    .xp_valid (xp_valid),
    .xp_ready (xp_ready),
    .busy     (busy)
  );

  out_slice u_slice (
    .clk       (clk),
    .rst       (rst),
    .xp_tile   (xp_tile),
    .xp_valid  (xp_valid),
    .xp_ready  (xp_ready),
    .out_tile  (out_tile),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

/* sim/tb_clock.sv */
/*
  Testbench clock
  Free-running 8 ns clock for the transposer testbench
*/

`timescale 1ns/10ps

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  // Half period of 4 ns
  always #4 clk = ~clk;

endmodule

/* sim/tb_xpose.sv */
/*
  Testbench for the block-matrix transposer
  Random tiles per matrix shape, queue reference model,
  assertion scoreboard on the output stream and a watchdog
*/

`timescale 1ns/10ps

`include "xpose_defs.svh"

module tb_xpose
  import xpose_pkg::*;
();

  localparam int TR = `XPOSE_TILE_ROWS;
  localparam int TC = `XPOSE_TILE_COLS;
  localparam int DW = `XPOSE_DATA_WIDTH;
  // 16 + 14 + 20 + 14 + 24 tiles over the test groups
  localparam int TOTAL_TILES = 88;

  logic        clk;
  logic        rst;
  rows_cfg_t   cfg_rows;
  cols_cfg_t   cfg_cols;
  tile_t       in_tile;
  logic        in_valid;
  logic        in_ready;
  tile_t       out_tile;
  logic        out_valid;
  logic        out_ready;

  tile_t       exp_q [$];
  tile_t       exp_head;
  logic        exp_avail = 1'b0;
  logic        pop_due = 1'b0;
  logic [31:0] data_state = 32'd28;
  logic [31:0] ready_state = 32'd28;
  int          ready_pct = 100;

  tb_clock u_clk (
    .clk (clk)
  );

  xpose_top uut (
    .clk       (clk),
    .rst       (rst),
    .cfg_rows  (cfg_rows),
    .cfg_cols  (cfg_cols),
    .in_tile   (in_tile),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_tile  (out_tile),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_data_rand();
    data_state = xorshift32(data_state);
    return data_state;
  endfunction

  function logic [31:0] next_ready_rand();
    ready_state = xorshift32(ready_state);
    return ready_state;
  endfunction

  // Zero becomes one tile and anything above the maximum becomes the maximum
  function automatic int clamp_dim(input int value, input int max_value);
    if (value == 0) begin
      return 1;
    end
    if (value > max_value) begin
      return max_value;
    end
    return value;
  endfunction

  // Element (r,c) moves to (c,r)
  function automatic tile_t transpose_tile(input tile_t t);
    tile_t res;
    int    r;
    int    c;
    res = '0;
    for (r = 0; r < TR; r++) begin
      for (c = 0; c < TC; c++) begin
        res[(c*TR+r)*DW +: DW] = t[(r*TC+c)*DW +: DW];
      end
    end
    return res;
  endfunction

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic refresh_head();
    exp_avail = (exp_q.size() != 0);
    exp_head  = exp_avail ? exp_q[0] : '0;
  endtask

  task automatic load_shape(input int rows_raw, input int cols_raw);
    cfg_rows = rows_cfg_t'(rows_raw);
    cfg_cols = cols_cfg_t'(cols_raw);
    repeat (2) @(posedge clk);
    #1;
  endtask

  // Sends one matrix in the current shape, then moves cfg on after tile change_at
  task automatic send_matrix(input int rows_raw, input int cols_raw, input int gap_pct,
                             input int next_rows, input int next_cols, input int change_at);
    tile_t tiles [$];
    int    n_rows;
    int    n_cols;
    int    i;
    int    j;
    int    k;
    logic  accepted;
    n_rows = clamp_dim(rows_raw, `XPOSE_MAX_ROWS);
    n_cols = clamp_dim(cols_raw, `XPOSE_MAX_COLS);
    for (k = 0; k < n_rows * n_cols; k++) begin
      tiles.push_back(tile_t'(next_data_rand()));
    end
    // Output tile (i,j) is input tile (j,i) transposed
    for (i = 0; i < n_cols; i++) begin
      for (j = 0; j < n_rows; j++) begin
        exp_q.push_back(transpose_tile(tiles[j*n_cols+i]));
      end
    end
    refresh_head();
    for (k = 0; k < n_rows * n_cols; k++) begin
      while ((next_data_rand() % 100) < gap_pct) begin
        in_valid = 1'b0;
        @(posedge clk);
        #1;
      end
      in_tile  = tiles[k];
      in_valid = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = in_ready;
        @(posedge clk);
        #1;
      end
      if (k == change_at) begin
        cfg_rows = rows_cfg_t'(next_rows);
        cfg_cols = cols_cfg_t'(next_cols);
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    // A few idle cycles catch stray output tiles
    repeat (4) @(posedge clk);
    #1;
  endtask

  // Transfers seen at negedge leave the queue one negedge after the checking edge
  always @(negedge clk) begin
    if (pop_due && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
    pop_due = !rst && out_valid && out_ready;
  end

  initial begin
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (ready_pct >= 100) begin
        out_ready = 1'b1;
      end else begin
        out_ready = ((next_ready_rand() % 100) < ready_pct);
      end
    end
  end

  a_out_due: assert property (@(posedge clk) disable iff (rst)
    (out_valid && out_ready) |-> exp_avail)
    else begin
      $display("An output tile was accepted at %0t while no tile was expected", $time);
      abort_run();
    end

  a_out_data: assert property (@(posedge clk) disable iff (rst)
    (out_valid && out_ready && exp_avail) |-> (out_tile == exp_head))
    else begin
      $display("** Error at %0t: expected tile %h, got tile %h",
               $time, $sampled(exp_head), $sampled(out_tile));
      abort_run();
    end

  // Stalled output keeps valid and data
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_tile)))
    else begin
      $display("** Error at %0t: output valid or tile changed while stalled", $time);
      abort_run();
    end

  initial begin
    repeat (200 * TOTAL_TILES + 1000) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", 200 * TOTAL_TILES + 1000);
    $display("Regression failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    rst      = 1'b1;
    cfg_rows = rows_cfg_t'(1);
    cfg_cols = cols_cfg_t'(1);
    in_tile  = '0;
    in_valid = 1'b0;
    refresh_head();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    a_reset: assert (!out_valid && in_ready)
      else begin
        $display("** Error at %0t: after reset out_valid=%b in_ready=%b, expected 0 and 1",
                 $time, out_valid, in_ready);
        abort_run();
      end

    // Full 4x4 with the output always ready
    load_shape(4, 4);
    send_matrix(4, 4, 0, 2, 3, 15);
    wait_drain();

    // Odd shapes back to back
    send_matrix(2, 3, 0, 1, 4, 5);
    send_matrix(1, 4, 0, 3, 1, 3);
    send_matrix(3, 1, 0, 1, 1, 2);
    send_matrix(1, 1, 0, 3, 4, 0);
    wait_drain();

    // Back-pressure and input gaps
    ready_pct = 50;
    send_matrix(3, 4, 30, 4, 2, 11);
    send_matrix(4, 2, 30, 2, 4, 7);

    // Shape change partway through a matrix
    send_matrix(2, 4, 20, 3, 2, 3);
    send_matrix(3, 2, 20, 0, 7, 5);
    wait_drain();

    // Clamping of 0 and 7
    send_matrix(0, 7, 20, 7, 0, 3);
    send_matrix(7, 0, 20, 7, 7, 3);
    send_matrix(7, 7, 20, 7, 7, 15);
    wait_drain();

    if (!out_valid) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Output still valid after every expected tile was seen");
      $display("Regression failed");
      $fatal(1, "Output not idle at the end");
    end
  end

endmodule

/* sim.f */
+incdir+logic
logic/xpose_pkg.sv
logic/tile_fifo.sv
logic/tile_transposer.sv
logic/shape_latch.sv
logic/out_slice.sv
logic/xpose_top.sv
sim/tb_clock.sv
sim/tb_xpose.sv

/* Makefile */
TOP = tb_xpose
RTL = logic/xpose_pkg.sv logic/tile_fifo.sv logic/tile_transposer.sv \
      logic/shape_latch.sv logic/out_slice.sv logic/xpose_top.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -f sim.f --top-module $(TOP) --Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/10ps +incdir+logic $(RTL) --top-module xpose_top

clean:
	rm -rf obj_dir sim.log
